// File: source/sequencer_pkg.sv
package sequencer_pkg;

    // Bus geometry
    localparam int axi_data_width_c = 32;
    localparam int axi_addr_width_c = 16;
    localparam int axi_strb_width_c = axi_data_width_c / 8;
    localparam int addr_lsb_c       = 2;

    // Word index of each register, byte offset is index times four
    typedef enum logic [1:0] {
        CONFIG_REG = 2'd0,  // 0x0
        BUFFER_REG = 2'd1,  // 0x4
        STATUS_REG = 2'd2   // 0x8
    } reg_index_t;

    ////////////////////////////////////////
    // CONFIG_REG fields
    ////////////////////////////////////////
    localparam int cfg_run_cmd_lsb_c    = 0;
    localparam int run_cmd_width_c      = 3;
    localparam int cfg_irq_en_bit_c     = 8;
    localparam int cfg_irq_len_lsb_c    = 16;
    localparam int irq_len_width_c      = 8;
    // Self-clearing strobe
    localparam int cfg_loop_start_bit_c = 26;

    // BUFFER_REG field, cleared by the start event
    localparam int buf_ready_bit_c = 24;

    // STATUS_REG fields
    localparam int status_run_bit_c  = 0;
    localparam int status_loop_bit_c = 1;

    // Only the all-ones pattern starts the sequencer
    typedef enum logic [run_cmd_width_c-1:0] {
        RUN_STOP  = 3'b000,
        RUN_START = 3'b111
    } run_cmd_e;

endpackage

// File: source/reg_access_if.sv
`timescale 1ns/10ps

interface reg_access_if;
    import sequencer_pkg::*;

    // Write side, one strobe per accepted write
    logic                        wr_en;
    reg_index_t                  wr_index;
    logic [axi_strb_width_c-1:0] wr_strb;
    logic [axi_data_width_c-1:0] wr_data;

    // Read side, data comes back registered
    logic                        rd_en;
    reg_index_t                  rd_index;
    logic [axi_data_width_c-1:0] rd_data;

    modport bus_mp (
        output wr_en, wr_index, wr_strb, wr_data, rd_en, rd_index,
        input  rd_data
    );

    modport regs_mp (
        input  wr_en, wr_index, wr_strb, wr_data, rd_en, rd_index,
        output rd_data
    );
endinterface

// File: source/axi_lite_slave.sv
`timescale 1ns/10ps

module axi_lite_slave (
    input  logic                                         S_AXI_ACLK,
    input  logic                                         S_AXI_ARESETN,
    input  logic [sequencer_pkg::axi_addr_width_c-1:0]   S_AXI_AWADDR,
    input  logic                                         S_AXI_AWVALID,
    output logic                                         S_AXI_AWREADY,
    input  logic [sequencer_pkg::axi_data_width_c-1:0]   S_AXI_WDATA,
    input  logic [sequencer_pkg::axi_strb_width_c-1:0]   S_AXI_WSTRB,
    input  logic                                         S_AXI_WVALID,
    output logic                                         S_AXI_WREADY,
    output logic [1:0]                                   S_AXI_BRESP,
    output logic                                         S_AXI_BVALID,
    input  logic                                         S_AXI_BREADY,
    input  logic [sequencer_pkg::axi_addr_width_c-1:0]   S_AXI_ARADDR,
    input  logic                                         S_AXI_ARVALID,
    output logic                                         S_AXI_ARREADY,
    output logic [sequencer_pkg::axi_data_width_c-1:0]   S_AXI_RDATA,
    output logic [1:0]                                   S_AXI_RRESP,
    output logic                                         S_AXI_RVALID,
    input  logic                                         S_AXI_RREADY,
    reg_access_if.bus_mp                                 bus
);
    import sequencer_pkg::*;

    logic                        wr_ready_q;
    logic                        bvalid_q;
    logic                        arready_q;
    logic                        rvalid_q;
    logic [axi_addr_width_c-1:0] awaddr_q;
    logic [axi_addr_width_c-1:0] araddr_q;
    logic                        wr_accept;
    logic                        wr_fire;
    logic                        rd_accept;
    logic                        rd_fire;

    ////////////////////////////////////////
    // Write channels
    ////////////////////////////////////////

    // Address and data are taken together, never with a response pending
    assign wr_accept = !wr_ready_q && !bvalid_q && S_AXI_AWVALID && S_AXI_WVALID;
    assign wr_fire   = wr_ready_q && S_AXI_AWVALID && S_AXI_WVALID;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
        end
        else
        begin
            wr_ready_q <= wr_accept;
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (S_AXI_BREADY)
                bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_accept)
            awaddr_q <= S_AXI_AWADDR;
    end

    ////////////////////////////////////////
    // Read channels
    ////////////////////////////////////////

    // One read in flight, the next address waits for RVALID to drop
    assign rd_accept = !arready_q && !rvalid_q && S_AXI_ARVALID;
    assign rd_fire   = arready_q && S_AXI_ARVALID && !rvalid_q;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end
        else
        begin
            arready_q <= rd_accept;
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (S_AXI_RREADY)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_accept)
            araddr_q <= S_AXI_ARADDR;
    end

    assign S_AXI_AWREADY = wr_ready_q;
    assign S_AXI_WREADY  = wr_ready_q;
    assign S_AXI_BVALID  = bvalid_q;
    assign S_AXI_BRESP   = 2'b00;
    assign S_AXI_ARREADY = arready_q;
    assign S_AXI_RVALID  = rvalid_q;
    assign S_AXI_RRESP   = 2'b00;
    assign S_AXI_RDATA   = bus.rd_data;

    // Word index from the latched byte address
    assign bus.wr_en    = wr_fire;
    assign bus.wr_index = reg_index_t'(awaddr_q[addr_lsb_c +: $bits(reg_index_t)]);
    assign bus.wr_strb  = S_AXI_WSTRB;
    assign bus.wr_data  = S_AXI_WDATA;
    assign bus.rd_en    = rd_fire;
    assign bus.rd_index = reg_index_t'(araddr_q[addr_lsb_c +: $bits(reg_index_t)]);

    // Responses hold until the master takes them
    bvalid_hold_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);
    rvalid_hold_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));
endmodule

// File: source/sequencer_regs.sv
`timescale 1ns/10ps

module sequencer_regs (
    input  logic                                       S_AXI_ACLK,
    input  logic                                       S_AXI_ARESETN,
    reg_access_if.regs_mp                              regs,
    input  logic                                       run_active_i,
    input  logic                                       loop_active_i,
    input  logic                                       start_event_i,
    output sequencer_pkg::run_cmd_e                    run_cmd_o,
    output logic                                       loop_start_o,
    output logic                                       irq_en_o,
    output logic [sequencer_pkg::irq_len_width_c-1:0]  irq_len_o
);
    import sequencer_pkg::*;

    logic [axi_data_width_c-1:0] config_q;
    logic [axi_data_width_c-1:0] buffer_q;
    logic [axi_data_width_c-1:0] config_d;
    logic [axi_data_width_c-1:0] buffer_d;
    logic [axi_data_width_c-1:0] status_w;
    logic [axi_data_width_c-1:0] read_mux;

    // Strobed bytes replace the old value, the rest are kept
    function automatic logic [axi_data_width_c-1:0] merge_bytes(
        input logic [axi_data_width_c-1:0] old_val,
        input logic [axi_data_width_c-1:0] new_val,
        input logic [axi_strb_width_c-1:0] strb
    );
        logic [axi_data_width_c-1:0] result;
        result = old_val;
        for (int b = 0; b < axi_strb_width_c; b++)
        begin
            if (strb[b])
                result[8*b +: 8] = new_val[8*b +: 8];
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Next register values
    ////////////////////////////////////////
    always_comb
    begin
        config_d = config_q;
        config_d[cfg_loop_start_bit_c] = 1'b0;
        buffer_d = buffer_q;
        if (start_event_i)
            buffer_d[buf_ready_bit_c] = 1'b0;
        // A bus write lands on top of the internal update
        if (regs.wr_en && regs.wr_index == CONFIG_REG)
            config_d = merge_bytes(config_d, regs.wr_data, regs.wr_strb);
        if (regs.wr_en && regs.wr_index == BUFFER_REG)
            buffer_d = merge_bytes(buffer_d, regs.wr_data, regs.wr_strb);
    end

    always_comb
    begin
        status_w = '0;
        status_w[status_run_bit_c]  = run_active_i;
        status_w[status_loop_bit_c] = loop_active_i;
    end

    always_comb
    begin
        case (regs.rd_index)
            CONFIG_REG: read_mux = config_q;
            BUFFER_REG: read_mux = buffer_q;
            STATUS_REG: read_mux = status_w;
            default:    read_mux = '0;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            config_q     <= '0;
            buffer_q     <= '0;
            regs.rd_data <= '0;
        end
        else
        begin
            config_q <= config_d;
            buffer_q <= buffer_d;
            if (regs.rd_en)
                regs.rd_data <= read_mux;
        end
    end

    assign run_cmd_o    = run_cmd_e'(config_q[cfg_run_cmd_lsb_c +: run_cmd_width_c]);
    assign loop_start_o = config_q[cfg_loop_start_bit_c];
    assign irq_en_o     = config_q[cfg_irq_en_bit_c];
    assign irq_len_o    = config_q[cfg_irq_len_lsb_c +: irq_len_width_c];

    // Strobe lasts one cycle even with back-to-back bus traffic
    loop_strobe_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        loop_start_o |=> !loop_start_o);
endmodule

// File: source/run_control.sv
`timescale 1ns/10ps

module run_control #(
    parameter int raster_period_p = 1250
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  sequencer_pkg::run_cmd_e run_cmd_i,
    input  logic                    loop_start_i,
    input  logic                    external_trigger_i,
    output logic                    run_active_o,
    output logic                    loop_active_o,
    output logic                    start_event_o
);
    import sequencer_pkg::*;

    localparam int cnt_width_c = $clog2(raster_period_p);
    localparam logic [cnt_width_c-1:0] cnt_last_c = cnt_width_c'(raster_period_p - 1);

    logic                   start_cmd;
    logic                   loop_run;
    logic                   loop_fire;
    logic                   trigger;
    logic                   run_q;
    logic                   run_d1_q;
    logic                   loop_en_q;
    logic [cnt_width_c-1:0] loop_cnt_q;

    assign start_cmd = run_cmd_i == RUN_START;

    // Loop counts from the strobe cycle on, so the first trigger
    // lands one raster period after the strobe edge
    assign loop_run  = start_cmd && (loop_start_i || loop_en_q);
    assign loop_fire = loop_run && loop_cnt_q == cnt_last_c;
    assign trigger   = external_trigger_i || loop_fire;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            run_q      <= 1'b0;
            run_d1_q   <= 1'b0;
            loop_en_q  <= 1'b0;
            loop_cnt_q <= '0;
        end
        else
        begin
            run_q     <= start_cmd && (trigger || run_q);
            run_d1_q  <= run_q;
            loop_en_q <= loop_run;
            if (!loop_run || loop_cnt_q == cnt_last_c)
                loop_cnt_q <= '0;
            else
                loop_cnt_q <= loop_cnt_q + 1'b1;
        end
    end

    assign run_active_o  = run_q;
    assign loop_active_o = loop_en_q;
    // First active cycle
    assign start_event_o = run_q && !run_d1_q;

    run_needs_start_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        run_active_o |-> $past(run_cmd_i) == RUN_START);
endmodule

// File: source/pulse_stretcher.sv
`timescale 1ns/10ps

module pulse_stretcher #(
    parameter int width_p = 8
) (
    input  logic               S_AXI_ACLK,
    input  logic               S_AXI_ARESETN,
    input  logic               event_i,
    input  logic [width_p-1:0] duration_i,
    output logic               pulse_o
);
    logic               fire;
    logic               active_q;
    logic [width_p-1:0] count_q;
    logic [width_p-1:0] duration_q;

    // Zero length never starts a pulse
    assign fire = event_i && duration_i != '0;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            active_q <= 1'b0;
            count_q  <= '0;
        end
        else if (fire)
        begin
            active_q <= 1'b1;
            count_q  <= width_p'(1);
        end
        else if (active_q)
        begin
            active_q <= count_q != duration_q;
            count_q  <= count_q + 1'b1;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (fire)
            duration_q <= duration_i;
    end

    assign pulse_o = active_q;
endmodule

// File: source/sequencer_top.sv
`timescale 1ns/10ps

module sequencer_top #(
    parameter int raster_period_p = 1250
) (
    input  logic                                         S_AXI_ACLK,
    input  logic                                         S_AXI_ARESETN,
    input  logic [sequencer_pkg::axi_addr_width_c-1:0]   S_AXI_AWADDR,
    input  logic                                         S_AXI_AWVALID,
    output logic                                         S_AXI_AWREADY,
    input  logic [sequencer_pkg::axi_data_width_c-1:0]   S_AXI_WDATA,
    input  logic [sequencer_pkg::axi_strb_width_c-1:0]   S_AXI_WSTRB,
    input  logic                                         S_AXI_WVALID,
    output logic                                         S_AXI_WREADY,
    output logic [1:0]                                   S_AXI_BRESP,
    output logic                                         S_AXI_BVALID,
    input  logic                                         S_AXI_BREADY,
    input  logic [sequencer_pkg::axi_addr_width_c-1:0]   S_AXI_ARADDR,
    input  logic                                         S_AXI_ARVALID,
    output logic                                         S_AXI_ARREADY,
    output logic [sequencer_pkg::axi_data_width_c-1:0]   S_AXI_RDATA,
    output logic [1:0]                                   S_AXI_RRESP,
    output logic                                         S_AXI_RVALID,
    input  logic                                         S_AXI_RREADY,
    input  logic                                         external_trigger_i,
    output logic                                         sequencer_active_o,
    output logic                                         tr_start_o,
    output logic                                         ps_interrupt_o
);
    import sequencer_pkg::*;

    // Transmit pulse lasts one raster period
    localparam int tr_width_c = $clog2(raster_period_p + 1);
    localparam logic [tr_width_c-1:0] tr_duration_c = tr_width_c'(raster_period_p);

    run_cmd_e                   run_cmd;
    logic                       loop_start;
    logic                       irq_en;
    logic [irq_len_width_c-1:0] irq_len;
    logic                       run_active;
    logic                       loop_active;
    logic                       start_event;

    reg_access_if reg_bus ();

    axi_lite_slave u_slave (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .S_AXI_AWADDR, .S_AXI_AWVALID, .S_AXI_AWREADY,
        .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
        .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
        .S_AXI_ARADDR, .S_AXI_ARVALID, .S_AXI_ARREADY,
        .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
        .bus (reg_bus.bus_mp)
    );

    sequencer_regs u_regs (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .regs          (reg_bus.regs_mp),
        .run_active_i  (run_active),
        .loop_active_i (loop_active),
        .start_event_i (start_event),
        .run_cmd_o     (run_cmd),
        .loop_start_o  (loop_start),
        .irq_en_o      (irq_en),
        .irq_len_o     (irq_len)
    );

    run_control #(.raster_period_p(raster_period_p)) u_run (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .run_cmd_i          (run_cmd),
        .loop_start_i       (loop_start),
        .external_trigger_i (external_trigger_i),
        .run_active_o       (run_active),
        .loop_active_o      (loop_active),
        .start_event_o      (start_event)
    );

    pulse_stretcher #(.width_p(tr_width_c)) u_tr_start (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .event_i    (start_event),
        .duration_i (tr_duration_c),
        .pulse_o    (tr_start_o)
    );

    // Start interrupt only when enabled
    pulse_stretcher #(.width_p(irq_len_width_c)) u_irq (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .event_i    (start_event && irq_en),
        .duration_i (irq_len),
        .pulse_o    (ps_interrupt_o)
    );

    assign sequencer_active_o = run_active;
endmodule

// File: test/sequencer_checker.sv
`timescale 1ns/10ps

module sequencer_checker #(
    parameter int raster_period_p = 1250
) (
    input logic                                       S_AXI_ACLK,
    input logic                                       S_AXI_ARESETN,
    input logic                                       S_AXI_AWREADY,
    input logic                                       S_AXI_WREADY,
    input logic                                       S_AXI_BVALID,
    input logic [1:0]                                 S_AXI_BRESP,
    input logic                                       S_AXI_BREADY,
    input logic                                       S_AXI_ARREADY,
    input logic                                       S_AXI_RVALID,
    input logic [1:0]                                 S_AXI_RRESP,
    input logic                                       S_AXI_RREADY,
    input logic [sequencer_pkg::axi_data_width_c-1:0] S_AXI_RDATA,
    input logic                                       sequencer_active_o,
    input logic                                       tr_start_o,
    input logic                                       ps_interrupt_o
);
    int          error_count = 0;
    int          cycle = 0;
    int          write_cyc = 0;
    int          active_cyc = 0;
    int          tr_cyc = 0;
    int          irq_cyc = 0;
    int          tr_pulses = 0;
    int          irq_pulses = 0;
    int          irq_len = 0;
    logic        irq_en = 1'b0;
    logic [31:0] read_exp [$];
    logic [31:0] rdata_q;
    logic        bvalid_q, bready_q, rvalid_q, rready_q;
    logic        active_q, tr_q, irq_q;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR t=%0d ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Check failed at %0d ns: %s", $time, what);
        error_count++;
    endtask

    ////////////////////////////////////////
    // Calls from the testbench
    ////////////////////////////////////////
    task automatic expect_read(input logic [31:0] value);
        read_exp.push_back(value);
    endtask

    task automatic set_irq(input logic en, input int len);
        irq_en  = en;
        irq_len = len;
    endtask

    // Cycles from the write landing edge to the rise of the active output
    task automatic check_start_delay(input int cycles);
        // The monitor records a rise at the edge after it happens
        @(posedge S_AXI_ACLK);
        #1;
        check_value("sequencer_active_o delay", active_cyc - write_cyc, cycles);
    endtask

    task automatic check_pulse_counts(input int tr, input int irq);
        check_value("tr_start_o pulses", tr_pulses, tr);
        check_value("ps_interrupt_o pulses", irq_pulses, irq);
    endtask

    task automatic check_idle();
        if ({sequencer_active_o, tr_start_o, ps_interrupt_o, S_AXI_BVALID, S_AXI_RVALID,
             S_AXI_AWREADY, S_AXI_WREADY, S_AXI_ARREADY} !== '0)
            report_failure("outputs, readies or response valids are not low");
    endtask

    ////////////////////////////////////////
    // Port monitor, samples the values of the cycle that just ended
    ////////////////////////////////////////
    always @(posedge S_AXI_ACLK)
    begin
        cycle++;
        if (S_AXI_ARESETN)
        begin
            if (S_AXI_BVALID && !bvalid_q)
                write_cyc = cycle;
            if (bvalid_q && !bready_q && !S_AXI_BVALID)
                report_failure("BVALID dropped before BREADY");
            if (rvalid_q && !rready_q && (!S_AXI_RVALID || S_AXI_RDATA !== rdata_q))
                report_failure("read response changed before RREADY");
            if ((S_AXI_ARREADY && S_AXI_RVALID) || (S_AXI_AWREADY && S_AXI_BVALID))
                report_failure("address accepted while a response was pending");
            // Every response is OKAY
            if (S_AXI_BVALID)
                check_value("S_AXI_BRESP", S_AXI_BRESP, 0);
            if (S_AXI_RVALID)
                check_value("S_AXI_RRESP", S_AXI_RRESP, 0);
            if (S_AXI_RVALID && S_AXI_RREADY)
            begin
                if (read_exp.size() == 0)
                    report_failure("read data arrived with no expected value");
                else
                    check_value("S_AXI_RDATA", S_AXI_RDATA, read_exp.pop_front());
            end
            if (sequencer_active_o && !active_q)
                active_cyc = cycle;
            // Both stretched pulses start one cycle after the run state
            if (tr_start_o && !tr_q)
            begin
                tr_cyc = cycle;
                check_value("tr_start_o delay", cycle - active_cyc, 1);
            end
            if (!tr_start_o && tr_q)
            begin
                tr_pulses++;
                check_value("tr_start_o width", cycle - tr_cyc, raster_period_p);
            end
            if (ps_interrupt_o && !irq_q)
            begin
                irq_cyc = cycle;
                check_value("ps_interrupt_o delay", cycle - active_cyc, 1);
                if (!irq_en || irq_len == 0)
                    report_failure("ps_interrupt_o pulsed while disabled or zero length");
            end
            if (!ps_interrupt_o && irq_q)
            begin
                irq_pulses++;
                check_value("ps_interrupt_o width", cycle - irq_cyc, irq_len);
            end
        end
        bvalid_q = S_AXI_BVALID;
        bready_q = S_AXI_BREADY;
        rvalid_q = S_AXI_RVALID;
        rready_q = S_AXI_RREADY;
        rdata_q  = S_AXI_RDATA;
        active_q = sequencer_active_o;
        tr_q     = tr_start_o;
        irq_q    = ps_interrupt_o;
    end
endmodule

// File: test/tb_sequencer.sv
`timescale 1ns/10ps

module tb_sequencer;
    import sequencer_pkg::*;

    localparam int raster_period_c = 20;
    localparam int timeout_c       = 200;

    logic                        S_AXI_ACLK;
    logic                        S_AXI_ARESETN;
    logic [axi_addr_width_c-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
    logic [axi_data_width_c-1:0] S_AXI_WDATA, S_AXI_RDATA;
    logic [axi_strb_width_c-1:0] S_AXI_WSTRB;
    logic [1:0]                  S_AXI_BRESP, S_AXI_RRESP;
    logic                        S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic                        S_AXI_BVALID, S_AXI_BREADY;
    logic                        S_AXI_ARVALID, S_AXI_ARREADY, S_AXI_RVALID, S_AXI_RREADY;
    logic                        external_trigger_i, sequencer_active_o;
    logic                        tr_start_o, ps_interrupt_o;
    integer                      seed = 32'hc059b424;
    int                          timeouts = 0;

    sequencer_top #(.raster_period_p(raster_period_c)) UUT (.*);

    sequencer_checker #(.raster_period_p(raster_period_c)) u_checker (.*);

    initial S_AXI_ACLK = 1'b0;
    always #4 S_AXI_ACLK = ~S_AXI_ACLK;

    // Inputs change shortly after the rising edge
    task automatic next_cycle();
        @(posedge S_AXI_ACLK);
        #1;
    endtask

    function automatic int back_pressure();
        return {$random(seed)} % 5;
    endfunction

    function automatic logic probe(input string name);
        case (name)
            "AWREADY": return S_AXI_AWREADY;
            "BVALID":  return S_AXI_BVALID;
            "ARREADY": return S_AXI_ARREADY;
            "RVALID":  return S_AXI_RVALID;
            default:   return sequencer_active_o;
        endcase
    endfunction

    task automatic wait_level(input string name, input logic level);
        int n;
        n = 0;
        while (probe(name) !== level && n < timeout_c)
        begin
            next_cycle();
            n++;
        end
        if (probe(name) !== level)
        begin
            $display("Timed out at %0d ns waiting for %s to go %0b", $time, name, level);
            timeouts++;
        end
    endtask

    task automatic check_operand_count(input int got, input int want);
        if (got != want)
            u_checker.report_failure("a stimulus line has missing operands");
    endtask

    ////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////
    task automatic axi_write(input logic [15:0] addr, input logic [3:0] strb,
                             input logic [31:0] data);
        S_AXI_AWADDR  = addr;
        S_AXI_WSTRB   = strb;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        wait_level("AWREADY", 1'b1);
        // Data is taken in the same cycle as the address
        u_checker.check_value("S_AXI_WREADY", S_AXI_WREADY, 1'b1);
        next_cycle();
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        u_checker.check_value("S_AXI_WREADY", S_AXI_WREADY, 1'b0);
        wait_level("BVALID", 1'b1);
        repeat (back_pressure()) next_cycle();
        S_AXI_BREADY = 1'b1;
        next_cycle();
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, input logic [31:0] expected);
        u_checker.expect_read(expected);
        u_checker.expect_read(32'h0);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        wait_level("ARREADY", 1'b1);
        next_cycle();
        // Next address to the unused index waits behind the pending response
        S_AXI_ARADDR = 16'h000c;
        wait_level("RVALID", 1'b1);
        repeat (back_pressure()) next_cycle();
        S_AXI_RREADY = 1'b1;
        next_cycle();
        S_AXI_RREADY = 1'b0;
        wait_level("ARREADY", 1'b1);
        next_cycle();
        S_AXI_ARVALID = 1'b0;
        wait_level("RVALID", 1'b1);
        repeat (back_pressure()) next_cycle();
        S_AXI_RREADY = 1'b1;
        next_cycle();
        S_AXI_RREADY = 1'b0;
    endtask

    initial
    begin
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] op_c;
        S_AXI_ARESETN      = 1'b0;
        S_AXI_AWADDR       = '0;
        S_AXI_AWVALID      = 1'b0;
        S_AXI_WDATA        = '0;
        S_AXI_WSTRB        = '0;
        S_AXI_WVALID       = 1'b0;
        S_AXI_BREADY       = 1'b0;
        S_AXI_ARADDR       = '0;
        S_AXI_ARVALID      = 1'b0;
        S_AXI_RREADY       = 1'b0;
        external_trigger_i = 1'b0;
        repeat (4) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        next_cycle();
        fd = $fopen("test/sequencer_stimulus.txt", "r");
        if (fd == 0)
            u_checker.report_failure("the stimulus file could not be opened");
        while (fd != 0 && !$feof(fd) && timeouts == 0)
        begin
            if ($fgets(line, fd) > 0 && $sscanf(line, "%c", cmd) == 1)
            begin
                case (cmd)
                    "W":
                    begin
                        fields = $sscanf(line, "W %h %h %h", op_a, op_b, op_c);
                        check_operand_count(fields, 3);
                        axi_write(op_a[15:0], op_b[3:0], op_c);
                    end
                    "R":
                    begin
                        fields = $sscanf(line, "R %h %h", op_a, op_b);
                        check_operand_count(fields, 2);
                        axi_read(op_a[15:0], op_b);
                    end
                    "I":
                    begin
                        fields = $sscanf(line, "I %d", op_a);
                        check_operand_count(fields, 1);
                        repeat (op_a) next_cycle();
                    end
                    "T":
                    begin
                        external_trigger_i = 1'b1;
                        next_cycle();
                        external_trigger_i = 1'b0;
                    end
                    "A":
                    begin
                        fields = $sscanf(line, "A %d", op_a);
                        check_operand_count(fields, 1);
                        wait_level("sequencer_active_o", op_a[0]);
                    end
                    "D":
                    begin
                        fields = $sscanf(line, "D %d", op_a);
                        check_operand_count(fields, 1);
                        u_checker.check_start_delay(op_a);
                    end
                    "E":
                    begin
                        fields = $sscanf(line, "E %d %d", op_a, op_b);
                        check_operand_count(fields, 2);
                        u_checker.set_irq(op_a[0], op_b);
                    end
                    "P":
                    begin
                        fields = $sscanf(line, "P %d %d", op_a, op_b);
                        check_operand_count(fields, 2);
                        u_checker.check_pulse_counts(op_a, op_b);
                    end
                    "Q":     u_checker.check_idle();
                    "#":     ;
                    "\n":    ;
                    default: u_checker.report_failure("unknown command in the stimulus file");
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);
        repeat (4) next_cycle();
        $display("Errors: %0d check failures, %0d timeouts", u_checker.error_count, timeouts);
        if (u_checker.error_count == 0 && timeouts == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end
endmodule

// File: test/sequencer_stimulus.txt
# W addr strb data, R addr expected (hex) | I cycles | T trigger | A active level
# D cycles from last write to start | E irq_en irq_len | P tr and irq pulse counts | Q idle
Q
R 0000 00000000
R 0004 00000000
R 0008 00000000
W 0004 5 a1b2c3d4
W 0004 a 11223344
R 0004 11b233d4
W 000c f ffffffff
W 0008 f ffffffff
R 000c 00000000
R 0008 00000000
E 1 5
W 0000 f 00050107
I 10
R 0008 00000000
T
A 1
R 0008 00000001
I 24
R 0004 10b233d4
W 0000 1 00
A 0
R 0008 00000000
E 1 0
W 0000 5 00000007
T
I 24
W 0000 1 00
E 0 5
W 0000 f 04050007
A 1
D 20
R 0008 00000003
R 0000 00050007
I 24
P 3 1
W 0000 f 00000000
A 0
R 0008 00000000
Q

// File: files.f
source/sequencer_pkg.sv
source/reg_access_if.sv
source/axi_lite_slave.sv
source/sequencer_regs.sv
source/run_control.sv
source/pulse_stretcher.sv
source/sequencer_top.sv
test/sequencer_checker.sv
test/tb_sequencer.sv

// File: Bender.yml
package:
  name: sequencer

sources:
  - source/sequencer_pkg.sv
  - source/reg_access_if.sv
  - source/axi_lite_slave.sv
  - source/sequencer_regs.sv
  - source/run_control.sv
  - source/pulse_stretcher.sv
  - source/sequencer_top.sv
  - target: test
    files:
      - test/sequencer_checker.sv
      - test/tb_sequencer.sv
